/* flist.f */
logic/morph_pkg.sv
logic/frame_mem.sv
logic/se_store.sv
logic/window_buffer.sv
logic/morph_pe.sv
logic/morph_ctrl.sv
logic/morph_top.sv
verification/tb_clk_gen.sv
verification/tb_checker.sv
verification/tb_morph.sv

/* logic/frame_mem.sv */
`timescale 1ns/1ps

module frame_mem
    import morph_pkg::*;
(
    input  logic              clk,
    input  logic              mem_we,
    input  logic [ADDR_W-1:0] mem_addr,
    input  logic [WORD_W-1:0] result_word,
    output logic [WORD_W-1:0] q
);

    logic [WORD_W-1:0] mem [IMG_WORDS];

    // single port where a write cycle leaves q unchanged
    always_ff @(posedge clk)
    begin
        if (mem_we)
            mem[mem_addr] <= result_word;
        else
            q <= mem[mem_addr];
    end

endmodule

/* logic/morph_ctrl.sv */
`timescale 1ns/1ps

module morph_ctrl
    import morph_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic                          op_valid,
    input  logic [OP_W-1:0]               op,
    output logic                          se_capture,
    output logic [$clog2(SE_BYTES)-1:0]   se_index,
    output logic                          shift_en,
    output logic                          fill_valid,
    output logic [$clog2(ROW_WORDS)-1:0]  col_word,
    output logic                          op_erode,
    output logic                          mem_we,
    output logic [ADDR_W-1:0]             mem_addr,
    output logic                          out_valid
);

    logic [1:0]        phase;
    logic [1:0]        phase_nxt;
    // words shifted into the buffer so far including flush zeros
    logic [ADDR_W:0]   feed_cnt;
    // base word of the window currently at the pe
    logic [ADDR_W:0]   wr_idx;
    logic [ADDR_W-1:0] out_cnt;
    logic [OP_W-1:0]   op_q;
    logic              start;
    logic              streaming;

    assign start     = (phase == PH_IDLE) && in_valid;
    assign streaming = (phase == PH_INPUT) || (phase == PH_FLUSH);

    // word 0 arrives while still idle, so it is fed in that same cycle
    assign fill_valid = start || (phase == PH_INPUT);
    assign shift_en   = fill_valid || (phase == PH_FLUSH);

    assign se_capture = fill_valid && (feed_cnt < SE_BYTES);
    assign se_index   = feed_cnt[$clog2(SE_BYTES)-1:0];

    assign wr_idx   = feed_cnt - (ADDR_W + 1)'(WIN_LEAD + 1);
    assign col_word = wr_idx[$clog2(ROW_WORDS)-1:0];

    // result k is ready once word k+WIN_LEAD has entered
    assign mem_we   = streaming && (feed_cnt > WIN_LEAD);
    assign mem_addr = (phase == PH_OUTPUT) ? out_cnt : wr_idx[ADDR_W-1:0];

    // anything but erosion runs as dilation
    assign op_erode = (op_q == OP_ERODE);

    always_comb
    begin
        phase_nxt = phase;
        case (phase)
            PH_IDLE:
            begin
                if (in_valid)
                    phase_nxt = PH_INPUT;
            end
            PH_INPUT:
            begin
                if (feed_cnt == IMG_WORDS - 1)
                    phase_nxt = PH_FLUSH;
            end
            PH_FLUSH:
            begin
                // last cycle here writes result word 255
                if (feed_cnt == IMG_WORDS + WIN_LEAD)
                    phase_nxt = PH_OUTPUT;
            end
            default:
            begin
                if (out_cnt == ADDR_W'(IMG_WORDS - 1))
                    phase_nxt = PH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase     <= PH_IDLE;
            feed_cnt  <= '0;
            out_cnt   <= '0;
            out_valid <= 1'b0;
        end
        else
        begin
            phase     <= phase_nxt;
            out_valid <= (phase == PH_OUTPUT);
            if (shift_en && (phase_nxt != PH_OUTPUT))
                feed_cnt <= feed_cnt + 1'b1;
            else
                feed_cnt <= '0;
            if (phase == PH_OUTPUT)
                out_cnt <= out_cnt + 1'b1;
            else
                out_cnt <= '0;
        end
    end

    // op is sampled only when a new image can start
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            op_q <= OP_DILATE;
        else if ((phase == PH_IDLE) && op_valid)
            op_q <= op;
    end

endmodule

/* logic/morph_pe.sv */
`timescale 1ns/1ps

module morph_pe
    import morph_pkg::*;
(
    input  logic [WIN_W-1:0]          win_row0,
    input  logic [WIN_W-1:0]          win_row1,
    input  logic [WIN_W-1:0]          win_row2,
    input  logic [WIN_W-1:0]          win_row3,
    input  logic [SE_BYTES*PIX_W-1:0] se_bytes,
    input  logic                      op_erode,
    output logic [WORD_W-1:0]         result_word
);

    logic [WIN_W-1:0] rows [SE_DIM];

    assign rows[0] = win_row0;
    assign rows[1] = win_row1;
    assign rows[2] = win_row2;
    assign rows[3] = win_row3;

    // pairwise halving from 16 values down to one
    function automatic logic [PIX_W-1:0] min_tree(input logic [SE_BYTES*PIX_W-1:0] v);
        logic [PIX_W-1:0] t [SE_BYTES];
        for (int k = 0; k < SE_BYTES; k++)
        begin
            t[k] = v[k*PIX_W +: PIX_W];
        end
        for (int n = SE_BYTES / 2; n > 0; n = n / 2)
        begin
            for (int k = 0; k < n; k++)
            begin
                t[k] = (t[2*k] < t[2*k+1]) ? t[2*k] : t[2*k+1];
            end
        end
        return t[0];
    endfunction

    function automatic logic [PIX_W-1:0] max_tree(input logic [SE_BYTES*PIX_W-1:0] v);
        logic [PIX_W-1:0] t [SE_BYTES];
        for (int k = 0; k < SE_BYTES; k++)
        begin
            t[k] = v[k*PIX_W +: PIX_W];
        end
        for (int n = SE_BYTES / 2; n > 0; n = n / 2)
        begin
            for (int k = 0; k < n; k++)
            begin
                t[k] = (t[2*k] > t[2*k+1]) ? t[2*k] : t[2*k+1];
            end
        end
        return t[0];
    endfunction

    for (genvar p = 0; p < PIX_PER_WORD; p++)
    begin : g_pix
        logic [SE_BYTES*PIX_W-1:0] diffs;
        logic [SE_BYTES*PIX_W-1:0] sums;

        always_comb
        begin
            logic [PIX_W-1:0] pix;
            logic [PIX_W-1:0] se_e;
            logic [PIX_W-1:0] se_d;
            logic [PIX_W:0]   sum;
            for (int i = 0; i < SE_DIM; i++)
            begin
                for (int j = 0; j < SE_DIM; j++)
                begin
                    pix  = rows[i][(p+j)*PIX_W +: PIX_W];
                    se_e = se_bytes[(i*SE_DIM+j)*PIX_W +: PIX_W];
                    // dilation walks the element back to front
                    se_d = se_bytes[(SE_BYTES-1-(i*SE_DIM+j))*PIX_W +: PIX_W];
                    sum  = {1'b0, pix} + {1'b0, se_d};
                    diffs[(i*SE_DIM+j)*PIX_W +: PIX_W] = (pix > se_e) ? pix - se_e : '0;
                    sums[(i*SE_DIM+j)*PIX_W +: PIX_W]  = sum[PIX_W] ? '1 : sum[PIX_W-1:0];
                end
            end
        end

        assign result_word[p*PIX_W +: PIX_W] = op_erode ? min_tree(diffs) : max_tree(sums);
    end

endmodule

/* logic/morph_pkg.sv */
package morph_pkg;

    // pixel and word geometry
    localparam int PIX_W        = 8;
    localparam int WORD_W       = 32;
    localparam int PIX_PER_WORD = WORD_W / PIX_W;

    // 32x32 image packed four pixels to a word
    localparam int IMG_DIM   = 32;
    localparam int ROW_WORDS = IMG_DIM / PIX_PER_WORD;
    localparam int IMG_WORDS = IMG_DIM * ROW_WORDS;
    localparam int ADDR_W    = $clog2(IMG_WORDS);

    // 4x4 structuring element
    localparam int SE_DIM   = 4;
    localparam int SE_BYTES = SE_DIM * SE_DIM;

    // three full rows plus one word ahead of the base word
    localparam int WIN_LEAD = (SE_DIM - 1) * ROW_WORDS + 1;

    // base word plus the three pixels spilling in from the next word
    localparam int WIN_W = (PIX_PER_WORD + SE_DIM - 1) * PIX_W;

    // op codes
    localparam int                OP_W      = 3;
    localparam logic [OP_W-1:0]   OP_ERODE  = 3'd2;
    localparam logic [OP_W-1:0]   OP_DILATE = 3'd3;

    // controller phases
    localparam logic [1:0] PH_IDLE   = 2'd0;
    localparam logic [1:0] PH_INPUT  = 2'd1;
    localparam logic [1:0] PH_FLUSH  = 2'd2;
    localparam logic [1:0] PH_OUTPUT = 2'd3;

endpackage

/* logic/morph_top.sv */
`timescale 1ns/1ps

module morph_top
    import morph_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  logic              op_valid,
    input  logic [WORD_W-1:0] pic_data,
    input  logic [PIX_W-1:0]  se_data,
    input  logic [OP_W-1:0]   op,
    output logic              out_valid,
    output logic [WORD_W-1:0] out_data
);

    logic                          se_capture;
    logic [$clog2(SE_BYTES)-1:0]   se_index;
    logic                          shift_en;
    logic                          fill_valid;
    logic [$clog2(ROW_WORDS)-1:0]  col_word;
    logic                          op_erode;
    logic                          mem_we;
    logic [ADDR_W-1:0]             mem_addr;
    logic [SE_BYTES*PIX_W-1:0]     se_bytes;
    logic [WIN_W-1:0]              win_row0;
    logic [WIN_W-1:0]              win_row1;
    logic [WIN_W-1:0]              win_row2;
    logic [WIN_W-1:0]              win_row3;
    logic [WORD_W-1:0]             result_word;

    morph_ctrl u_morph_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .op_valid   (op_valid),
        .op         (op),
        .se_capture (se_capture),
        .se_index   (se_index),
        .shift_en   (shift_en),
        .fill_valid (fill_valid),
        .col_word   (col_word),
        .op_erode   (op_erode),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .out_valid  (out_valid)
    );

    se_store u_se_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .se_capture (se_capture),
        .se_index   (se_index),
        .se_data    (se_data),
        .se_bytes   (se_bytes)
    );

    window_buffer u_window_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .shift_en   (shift_en),
        .fill_valid (fill_valid),
        .pic_data   (pic_data),
        .col_word   (col_word),
        .win_row0   (win_row0),
        .win_row1   (win_row1),
        .win_row2   (win_row2),
        .win_row3   (win_row3)
    );

    morph_pe u_morph_pe (
        .win_row0    (win_row0),
        .win_row1    (win_row1),
        .win_row2    (win_row2),
        .win_row3    (win_row3),
        .se_bytes    (se_bytes),
        .op_erode    (op_erode),
        .result_word (result_word)
    );

    frame_mem u_frame_mem (
        .clk         (clk),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .result_word (result_word),
        .q           (out_data)
    );

endmodule

/* logic/se_store.sv */
`timescale 1ns/1ps

module se_store
    import morph_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        se_capture,
    input  logic [$clog2(SE_BYTES)-1:0] se_index,
    input  logic [PIX_W-1:0]            se_data,
    output logic [SE_BYTES*PIX_W-1:0]   se_bytes
);

    // byte n of the element sits at bits n*8 upward
    logic [SE_BYTES*PIX_W-1:0] se_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            se_q <= '0;
        else if (se_capture)
            se_q[se_index*PIX_W +: PIX_W] <= se_data;
    end

    assign se_bytes = se_q;

endmodule

/* logic/window_buffer.sv */
`timescale 1ns/1ps

module window_buffer
    import morph_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          shift_en,
    input  logic                          fill_valid,
    input  logic [WORD_W-1:0]             pic_data,
    input  logic [$clog2(ROW_WORDS)-1:0]  col_word,
    output logic [WIN_W-1:0]              win_row0,
    output logic [WIN_W-1:0]              win_row1,
    output logic [WIN_W-1:0]              win_row2,
    output logic [WIN_W-1:0]              win_row3
);

    localparam int PAD_W = (SE_DIM - 1) * PIX_W;

    // index 0 holds the oldest word, the window base of row 0
    logic [WORD_W-1:0] chain [WIN_LEAD+1];
    logic [WORD_W-1:0] in_word;
    logic [WIN_W-1:0]  rows  [SE_DIM];

    // zeros during flush give the bottom padding
    assign in_word = fill_valid ? pic_data : '0;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int k = 0; k <= WIN_LEAD; k++)
            begin
                chain[k] <= '0;
            end
        end
        else if (shift_en)
        begin
            for (int k = 0; k < WIN_LEAD; k++)
            begin
                chain[k] <= chain[k+1];
            end
            chain[WIN_LEAD] <= in_word;
        end
    end

    for (genvar r = 0; r < SE_DIM; r++)
    begin : g_row
        // last word of a row has nothing to its right
        assign rows[r] = (col_word == ROW_WORDS - 1) ?
                         {{PAD_W{1'b0}}, chain[r*ROW_WORDS]} :
                         {chain[r*ROW_WORDS+1][PAD_W-1:0], chain[r*ROW_WORDS]};
    end

    assign win_row0 = rows[0];
    assign win_row1 = rows[1];
    assign win_row2 = rows[2];
    assign win_row3 = rows[3];

endmodule

/* verification/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker
    import morph_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  logic              op_valid,
    input  logic [OP_W-1:0]   op,
    input  logic [WORD_W-1:0] pic_data,
    input  logic [PIX_W-1:0]  se_data,
    input  logic              out_valid,
    input  logic [WORD_W-1:0] out_data,
    output logic [31:0]       tests_done,
    output logic [31:0]       tests_failed
);

    logic [PIX_W-1:0]  img [IMG_DIM*IMG_DIM];
    logic [PIX_W-1:0]  se [SE_BYTES];
    logic [WORD_W-1:0] exp_words [IMG_WORDS];
    logic [OP_W-1:0]   op_seen;
    logic              armed;
    int                in_cnt;
    int                out_cnt;
    int                err_cnt;

    initial
    begin
        op_seen      = OP_DILATE;
        armed        = 1'b0;
        in_cnt       = 0;
        out_cnt      = 0;
        err_cnt      = 0;
        tests_done   = '0;
        tests_failed = '0;
    end

    // anything past the right or bottom edge reads as zero
    function automatic int pix_at(input int r, input int c);
        if (r >= IMG_DIM || c >= IMG_DIM)
            return 0;
        return int'(img[r*IMG_DIM+c]);
    endfunction

    task automatic build_expected();
        logic [WORD_W-1:0] word;
        int                r;
        int                c;
        int                acc;
        int                term;
        for (int k = 0; k < IMG_WORDS; k++)
        begin
            r = k / ROW_WORDS;
            for (int p = 0; p < PIX_PER_WORD; p++)
            begin
                c   = (k % ROW_WORDS) * PIX_PER_WORD + p;
                acc = (op_seen == OP_ERODE) ? 255 : 0;
                for (int i = 0; i < SE_DIM; i++)
                begin
                    for (int j = 0; j < SE_DIM; j++)
                    begin
                        if (op_seen == OP_ERODE)
                        begin
                            term = pix_at(r + i, c + j) - int'(se[i*SE_DIM+j]);
                            if (term < 0)
                                term = 0;
                            if (term < acc)
                                acc = term;
                        end
                        else
                        begin
                            // element taken back to front
                            term = pix_at(r + i, c + j) + int'(se[SE_BYTES-1-(i*SE_DIM+j)]);
                            if (term > 255)
                                term = 255;
                            if (term > acc)
                                acc = term;
                        end
                    end
                end
                word[p*PIX_W +: PIX_W] = acc[PIX_W-1:0];
            end
            exp_words[k] = word;
        end
    endtask

    task automatic finish_test();
        if (out_cnt != IMG_WORDS)
        begin
            $display("test %0d: out_valid held for %0d words instead of %0d",
                     tests_done, out_cnt, IMG_WORDS);
            err_cnt++;
        end
        $display("test %0d (op %0d): %s, %0d words, %0d errors", tests_done, op_seen,
                 (err_cnt == 0) ? "passed" : "failed", out_cnt, err_cnt);
        tests_done = tests_done + 1;
        if (err_cnt != 0)
            tests_failed = tests_failed + 1;
        err_cnt = 0;
        out_cnt = 0;
        armed   = 1'b0;
    endtask

    always @(posedge clk)
    begin
        if (rst_n)
        begin
            // capture image and element as the DUT sees them
            if (in_valid)
            begin
                if (in_cnt == 0 && op_valid)
                    op_seen = op;
                if (in_cnt < IMG_WORDS)
                begin
                    for (int b = 0; b < PIX_PER_WORD; b++)
                        img[in_cnt*PIX_PER_WORD+b] = pic_data[b*PIX_W +: PIX_W];
                end
                if (in_cnt < SE_BYTES)
                    se[in_cnt] = se_data;
                in_cnt++;
            end
            else if (in_cnt != 0)
            begin
                build_expected();
                armed  = 1'b1;
                in_cnt = 0;
            end

            // output side
            if (out_valid)
            begin
                if (!armed && out_cnt == 0)
                begin
                    $display("out_valid went high with no image loaded");
                    err_cnt++;
                end
                else if (armed && out_cnt < IMG_WORDS && out_data !== exp_words[out_cnt])
                begin
                    $display("** Error: out_data word %0d: expected %h, actual %h",
                             out_cnt, exp_words[out_cnt], out_data);
                    err_cnt++;
                end
                out_cnt++;
            end
            else if (out_cnt != 0)
            begin
                finish_test();
            end
        end
    end

endmodule

/* verification/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen
(
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 5;
    localparam int RST_CYCLES  = 16;

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release away from the rising edge
    initial
    begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* verification/tb_morph.sv */
`timescale 1ns/1ps

module tb_morph
    import morph_pkg::*;
;

    localparam int          N_TESTS        = 6;
    localparam int          RST_CYCLES     = 16;
    localparam int          TIMEOUT_MARGIN = 64;
    localparam int          TIMEOUT_CYCLES =
        N_TESTS * (IMG_WORDS + WIN_LEAD + IMG_WORDS + TIMEOUT_MARGIN) + RST_CYCLES;
    localparam logic [31:0] LFSR_SEED      = 32'h872d_1d8d;

    // image kinds
    localparam int IMG_RAND  = 0;
    localparam int IMG_RAMP  = 1;
    localparam int IMG_CONST = 2;
    // element kinds
    localparam int SE_ZERO = 0;
    localparam int SE_RAND = 1;
    localparam int SE_FULL = 2;

    localparam logic [PIX_W-1:0] CONST_PIX = 8'h40;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    logic              op_valid;
    logic [OP_W-1:0]   op;
    logic [WORD_W-1:0] pic_data;
    logic [PIX_W-1:0]  se_data;
    logic              out_valid;
    logic [WORD_W-1:0] out_data;
    logic [31:0]       tests_done;
    logic [31:0]       tests_failed;

    logic [OP_W-1:0]   t_op [N_TESTS];
    int                t_img [N_TESTS];
    int                t_se [N_TESTS];
    string             t_name [N_TESTS];

    logic [WORD_W-1:0] stim_pic [IMG_WORDS];
    logic [PIX_W-1:0]  stim_se [SE_BYTES];
    logic [31:0]       lfsr;
    int                cycle_cnt = 0;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    morph_top u_morph_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op_valid  (op_valid),
        .pic_data  (pic_data),
        .se_data   (se_data),
        .op        (op),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    tb_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .op_valid     (op_valid),
        .op           (op),
        .pic_data     (pic_data),
        .se_data      (se_data),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .tests_done   (tests_done),
        .tests_failed (tests_failed)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int nbits, output logic [31:0] val);
        val = '0;
        for (int b = 0; b < nbits; b++)
        begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic add_test(input int t, input logic [OP_W-1:0] op_code, input int img_kind,
                            input int se_kind, input string name);
        t_op[t]   = op_code;
        t_img[t]  = img_kind;
        t_se[t]   = se_kind;
        t_name[t] = name;
    endtask

    task automatic build_stimulus(input int t);
        logic [31:0]       rv;
        logic [WORD_W-1:0] word;
        for (int w = 0; w < IMG_WORDS; w++)
        begin
            case (t_img[t])
                IMG_RAND:
                begin
                    rand_bits(WORD_W, rv);
                    word = rv;
                end
                IMG_RAMP:
                begin
                    for (int b = 0; b < PIX_PER_WORD; b++)
                        word[b*PIX_W +: PIX_W] = PIX_W'(w * PIX_PER_WORD + b);
                end
                default:
                    word = {PIX_PER_WORD{CONST_PIX}};
            endcase
            stim_pic[w] = word;
        end
        for (int s = 0; s < SE_BYTES; s++)
        begin
            case (t_se[t])
                SE_ZERO:
                    stim_se[s] = '0;
                SE_RAND:
                begin
                    rand_bits(PIX_W, rv);
                    stim_se[s] = rv[PIX_W-1:0];
                end
                default:
                    stim_se[s] = '1;
            endcase
        end
    endtask

    task automatic drive_image(input int t);
        for (int w = 0; w < IMG_WORDS; w++)
        begin
            @(negedge clk);
            in_valid = 1'b1;
            op_valid = (w == 0);
            op       = t_op[t];
            pic_data = stim_pic[w];
            se_data  = (w < SE_BYTES) ? stim_se[w] : '0;
        end
        @(negedge clk);
        in_valid = 1'b0;
        op_valid = 1'b0;
        pic_data = '0;
        se_data  = '0;
    endtask

    // waits for the output burst to start and then end
    task automatic wait_output();
        while (out_valid !== 1'b1)
            @(negedge clk);
        while (out_valid === 1'b1)
            @(negedge clk);
    endtask

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout: no finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial
    begin
        in_valid = 1'b0;
        op_valid = 1'b0;
        op       = '0;
        pic_data = '0;
        se_data  = '0;
        lfsr     = LFSR_SEED;

        add_test(0, OP_ERODE, IMG_RAND, SE_ZERO, "erode, random image, zero element");
        add_test(1, OP_ERODE, IMG_RAND, SE_RAND, "erode, random image, random element");
        add_test(2, OP_DILATE, IMG_RAND, SE_RAND, "dilate, random image, random element");
        add_test(3, OP_DILATE, IMG_CONST, SE_FULL, "dilate, constant image, element all 255");
        add_test(4, OP_ERODE, IMG_RAMP, SE_RAND, "erode right after dilate, ramp image");
        add_test(5, 3'd5, IMG_RAMP, SE_RAND, "unlisted op runs as dilation");

        while (rst_n !== 1'b1)
            @(negedge clk);
        @(negedge clk);

        for (int t = 0; t < N_TESTS; t++)
        begin
            $display("running test %0d: %s", t, t_name[t]);
            build_stimulus(t);
            drive_image(t);
            wait_output();
            repeat (8) @(negedge clk);
        end

        $display("tests run: %0d, passed: %0d, failed: %0d",
                 tests_done, tests_done - tests_failed, tests_failed);
        if (tests_failed == 0 && tests_done == N_TESTS)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule
